// ==== include/scan_codes.svh ====
// scan code set 2 values for the ten tracked keys
`ifndef SCAN_CODES_SVH
`define SCAN_CODES_SVH

// arrow keys, always sent behind an E0 prefix
localparam logic [7:0] SC_LEFT  = 8'h6B;
localparam logic [7:0] SC_RIGHT = 8'h74;
localparam logic [7:0] SC_UP    = 8'h75;
localparam logic [7:0] SC_DOWN  = 8'h72;

// plain single byte codes
localparam logic [7:0] SC_W     = 8'h1D;
localparam logic [7:0] SC_A     = 8'h1C;
localparam logic [7:0] SC_S     = 8'h1B;
localparam logic [7:0] SC_D     = 8'h23;
localparam logic [7:0] SC_SPACE = 8'h29;
// main enter key, keypad enter is E0 5A and is not tracked
localparam logic [7:0] SC_ENTER = 8'h5A;

`endif

// ==== src/ps2_pkg.sv ====
// ps2 package, frame layout and protocol constants of the device-to-host link
package ps2_pkg;

    // one data byte as carried by a single frame
    typedef logic [7:0] ps2_byte_t;

    // start bit, eight data bits lsb first, odd parity, stop bit
    localparam int FRAME_BITS = 11;

    // position of the next bit inside a frame, 0 to FRAME_BITS-1
    typedef logic [3:0] bit_index_t;

    // prefix bytes of scan code set 2
    // E0 marks an extended key, the following code belongs to the second table
    localparam ps2_byte_t PREFIX_EXTENDED = 8'hE0;
    // F0 marks a release, the next code names the key that went up
    localparam ps2_byte_t PREFIX_BREAK = 8'hF0;

    // system clock cycles without a ps2 clock fall before a half frame is dropped
    // 50000 cycles is 1 ms at 50 MHz, far longer than one ps2 bit period
    // (a keyboard clocks at 10 to 16.7 kHz, so bits come every 60 to 100 us)
    localparam logic [31:0] DEFAULT_IDLE_TIMEOUT = 32'd50000;

endpackage

// ==== src/key_pkg.sv ====
// key package holding indices and the scan code lookup table of the tracked keys
package key_pkg;

    // raw scan code values
    `include "scan_codes.svh"

    // bit position of each key on the output vector
    // arrow keys take the low four bits
    typedef enum logic [3:0] {
        KEY_LEFT  = 4'd0,
        KEY_RIGHT = 4'd1,
        KEY_UP    = 4'd2,
        KEY_DOWN  = 4'd3,
        KEY_W     = 4'd4,
        KEY_A     = 4'd5,
        KEY_S     = 4'd6,
        KEY_D     = 4'd7,
        KEY_SPACE = 4'd8,
        KEY_ENTER = 4'd9
    } key_index_e;

    localparam int KEY_COUNT = 10;

    // one bit per key indexed by key_index_e
    typedef logic [KEY_COUNT-1:0] key_vec_t;

    // a key matches only when code and extended flag both agree
    typedef struct packed {
        logic [7:0] code;
        logic       extended;
    } key_code_t;

    // entry i describes the key with index i
    localparam key_code_t KEY_TABLE [KEY_COUNT] = '{
        '{code: SC_LEFT,  extended: 1'b1},
        '{code: SC_RIGHT, extended: 1'b1},
        '{code: SC_UP,    extended: 1'b1},
        '{code: SC_DOWN,  extended: 1'b1},
        '{code: SC_W,     extended: 1'b0},
        '{code: SC_A,     extended: 1'b0},
        '{code: SC_S,     extended: 1'b0},
        '{code: SC_D,     extended: 1'b0},
        '{code: SC_SPACE, extended: 1'b0},
        '{code: SC_ENTER, extended: 1'b0}
    };

endpackage

// ==== src/ps2_frame_counter.sv ====
// ps2 frame counter, tracks the bit position and drops stalled frames
`timescale 1ns/1ps

module ps2_frame_counter
    import ps2_pkg::*;
#(
    parameter logic [31:0] IDLE_TIMEOUT = DEFAULT_IDLE_TIMEOUT
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       fall,
    output bit_index_t bit_index,
    output logic       frame_done
);

    // cycles since the last ps2 clock fall, saturates at IDLE_TIMEOUT
    logic [31:0] idle_count;

    // last bit of the frame is the stop bit
    localparam bit_index_t LAST_BIT = bit_index_t'(FRAME_BITS - 1);

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            bit_index  <= '0;
            frame_done <= 1'b0;
            idle_count <= '0;
        end else begin
            // strobe only, cleared unless the stop bit arrives now
            frame_done <= 1'b0;

            if (fall) begin
                // every fall restarts the idle window
                idle_count <= '0;
                if (bit_index == LAST_BIT) begin
                    // eleventh bit taken, frame complete
                    bit_index  <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_index <= bit_index + 1'b1;
                end
            end else if (idle_count >= IDLE_TIMEOUT) begin
                // line went quiet mid frame, a glitch or an unplugged device
                // realign so the next start bit lands on index 0
                bit_index <= '0;
            end else begin
                idle_count <= idle_count + 1'b1;
            end
        end
    end

endmodule

// ==== src/ps2_receiver.sv ====
// ps2 receiver, samples device-to-host frames and presents checked bytes
`timescale 1ns/1ps

module ps2_receiver
    import ps2_pkg::*;
#(
    parameter logic [31:0] IDLE_TIMEOUT = DEFAULT_IDLE_TIMEOUT
) (
    input  logic      CLOCK_50,
    input  logic      reset,
    input  logic      ps2_clk,
    input  logic      ps2_dat,
    output ps2_byte_t rx_byte,
    output logic      rx_valid
);

    // two flop synchronizers, lines idle high
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    // previous synchronized clock level for edge detection
    logic       clk_prev;
    logic       fall;

    // bit position of the next sample and end of frame strobe
    bit_index_t bit_index;
    logic       frame_done;

    // frame bits, [0] start, [8:1] data lsb first, [9] parity, [10] stop
    logic [FRAME_BITS-1:0] frame_bits;
    logic                  frame_ok;

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on the rising edge, so sample on the fall
    assign fall = clk_prev & ~clk_sync[1];

    ps2_frame_counter #(
        .IDLE_TIMEOUT(IDLE_TIMEOUT)
    ) ps2_frame_counter_inst (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .fall      (fall),
        .bit_index (bit_index),
        .frame_done(frame_done)
    );

    // bits land at their frame position, older bits of a dropped frame get overwritten
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            frame_bits[bit_index] <= dat_sync[1];
        end
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_bits[0] & frame_bits[10] & (^frame_bits[9:1]);

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            rx_valid <= 1'b0;
        end else begin
            // a bad frame is dropped without notice
            rx_valid <= frame_done & frame_ok;
        end
    end

    // payload register, only meaningful while rx_valid is high
    always_ff @(posedge CLOCK_50) begin
        if (frame_done) begin
            rx_byte <= frame_bits[8:1];
        end
    end

endmodule

// ==== src/scan_code_fsm.sv ====
// scan code decoder, follows E0 and F0 prefixes and emits key make and break events
`timescale 1ns/1ps

module scan_code_fsm
    import ps2_pkg::*;
    import key_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       reset,
    input  ps2_byte_t  rx_byte,
    input  logic       rx_valid,
    output logic       key_event,
    output key_index_e key_id,
    output logic       key_down
);

    // bit 1 is the extended flag, bit 0 the break flag
    typedef enum logic [1:0] {
        ST_MAKE      = 2'b00,
        ST_BREAK     = 2'b01,
        ST_EXT_MAKE  = 2'b10,
        ST_EXT_BREAK = 2'b11
    } prefix_state_e;

    prefix_state_e state;
    logic          is_extended;
    logic          is_break;

    // table lookup result for the current byte
    logic          hit;
    key_index_e    hit_id;

    assign is_extended = state[1];
    assign is_break    = state[0];

    // code and extended flag must both agree, so plain 75 (keypad 8) is not up
    always_comb begin
        hit    = 1'b0;
        hit_id = KEY_LEFT;
        for (int i = 0; i < KEY_COUNT; i++) begin
            if (KEY_TABLE[i].code == rx_byte && KEY_TABLE[i].extended == is_extended) begin
                hit    = 1'b1;
                hit_id = key_index_e'(i);
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            state     <= ST_MAKE;
            key_event <= 1'b0;
        end else begin
            key_event <= 1'b0;
            if (rx_valid) begin
                if (rx_byte == PREFIX_EXTENDED) begin
                    state <= ST_EXT_MAKE;
                end else if (rx_byte == PREFIX_BREAK) begin
                    // keep the extended flag, E0 F0 xx is an extended release
                    state <= is_extended ? ST_EXT_BREAK : ST_BREAK;
                end else begin
                    // final byte of a sequence, tracked or not
                    state     <= ST_MAKE;
                    key_event <= hit;
                end
            end
        end
    end

    // event payload, qualified by key_event
    always_ff @(posedge CLOCK_50) begin
        if (rx_valid) begin
            key_id   <= hit_id;
            key_down <= ~is_break;
        end
    end

endmodule

// ==== src/key_state_table.sv ====
// key state table, keeps press and lock bits per key and drives hold or pulse outputs
`timescale 1ns/1ps

module key_state_table
    import key_pkg::*;
#(
    // 0 holds the output while pressed, 1 gives one cycle on the first make
    parameter bit PULSE_MODE = 1'b0
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       key_event,
    input  key_index_e key_id,
    input  logic       key_down,
    output key_vec_t   keys
);

    // current keyboard state as reported by make and break codes
    key_vec_t press;
    // press delayed one cycle
    key_vec_t lock;

    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            press <= '0;
        end else if (key_event) begin
            // typematic repeats rewrite the same value, no change
            press[key_id] <= key_down;
        end
    end

    // lock rises one cycle after press and falls one cycle after it
    always_ff @(posedge CLOCK_50) begin
        if (!reset) begin
            lock <= '0;
        end else begin
            lock <= press;
        end
    end

    // only the first cycle of a press has press high while lock is still low
    // a held key keeps lock high, so repeats give no further pulse
    // a release never pulses since press is already low
    always_comb begin
        if (PULSE_MODE) begin
            keys = press & ~lock;
        end else begin
            keys = press;
        end
    end

endmodule

// ==== src/keyboard_tracker.sv ====
// keyboard tracker top, ps2 receive, scan code decode and key state for ten keys
`timescale 1ns/1ps

module keyboard_tracker #(
    parameter bit          PULSE_MODE   = 1'b0,
    parameter logic [31:0] IDLE_TIMEOUT = ps2_pkg::DEFAULT_IDLE_TIMEOUT
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [9:0] keys
);

    // receiver to decoder
    ps2_pkg::ps2_byte_t  rx_byte;
    logic                rx_valid;

    // decoder to key table
    logic                key_event;
    key_pkg::key_index_e key_id;
    logic                key_down;

    ps2_receiver #(
        .IDLE_TIMEOUT(IDLE_TIMEOUT)
    ) ps2_receiver_inst (
        .CLOCK_50(CLOCK_50),
        .reset   (reset),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    scan_code_fsm scan_code_fsm_inst (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .key_event(key_event),
        .key_id   (key_id),
        .key_down (key_down)
    );

    // outputs move two cycles after rx_valid
    key_state_table #(
        .PULSE_MODE(PULSE_MODE)
    ) key_state_table_inst (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .key_event(key_event),
        .key_id   (key_id),
        .key_down (key_down),
        .keys     (keys)
    );

endmodule

// ==== verification/key_monitor.sv ====
// key monitor, compares tracker outputs and pulse totals with the expected state
`timescale 1ns/1ps

module key_monitor #(
    parameter bit pulse_mode     = 1'b0,
    // cycles allowed for the outputs to reach the expected state
    parameter int timeout_cycles = 100
) (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic [9:0] keys,
    input  logic       check_req,
    input  logic [9:0] exp_keys,
    input  int         exp_pulses,
    output logic       check_done,
    output int         error_count
);

    // output cycles seen high, summed over all keys
    // a pulse longer than one cycle counts more than once
    int pulse_count = 0;

    always @(posedge CLOCK_50) begin
        if (reset) begin
            pulse_count <= pulse_count + $countones(keys);
        end
    end

    function automatic logic outputs_match();
        return (keys === exp_keys) && (!pulse_mode || pulse_count == exp_pulses);
    endfunction

    // one comparison per request, answered with a one cycle done
    initial begin : compare
        int waited;
        error_count = 0;
        check_done  = 1'b0;
        forever begin
            @(posedge CLOCK_50);
            if (check_req) begin
                waited = 0;
                while (!outputs_match() && waited < timeout_cycles) begin
                    @(posedge CLOCK_50);
                    waited++;
                end
                if (keys !== exp_keys) begin
                    error_count++;
                    $display("FAILED keys: expected %h, actual %h", exp_keys, keys);
                end
                if (pulse_mode && pulse_count != exp_pulses) begin
                    error_count++;
                    $display("FAILED pulse_count: expected %h, actual %h",
                             exp_pulses, pulse_count);
                end
                check_done <= 1'b1;
                @(posedge CLOCK_50);
                check_done <= 1'b0;
            end
        end
    end

endmodule

// ==== verification/tb_keyboard_tracker.sv ====
// keyboard tracker testbench driving lfsr ps2 frames against a reference key model
`timescale 1ns/1ps

module tb_keyboard_tracker
    import ps2_pkg::*;
    import key_pkg::*;
#(
    parameter bit pulse_mode = 1'b0
) ();

    // system clock cycles per half ps2 clock period
    localparam int          HALF_BIT       = 20;
    // short idle window keeps the abandoned frame test fast
    localparam logic [31:0] IDLE_CYCLES    = 32'd200;
    localparam int          ANSWER_TIMEOUT = 400;

    logic       CLOCK_50;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [9:0] keys;

    // request and answer lines to the monitor
    logic       check_req;
    logic       check_done;
    logic [9:0] exp_keys;
    int         exp_pulses;
    int         monitor_errors;

    // reference model state
    key_vec_t    press_model;
    int          pulse_model;
    logic [31:0] lfsr_state;
    int          tb_errors;
    int          check_count;

    always #4 CLOCK_50 = ~CLOCK_50;

    keyboard_tracker #(
        .PULSE_MODE  (pulse_mode),
        .IDLE_TIMEOUT(IDLE_CYCLES)
    ) keyboard_tracker_inst (
        .CLOCK_50(CLOCK_50),
        .reset   (reset),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .keys    (keys)
    );

    key_monitor #(
        .pulse_mode(pulse_mode)
    ) key_monitor_inst (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .keys       (keys),
        .check_req  (check_req),
        .exp_keys   (exp_keys),
        .exp_pulses (exp_pulses),
        .check_done (check_done),
        .error_count(monitor_errors)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // hold mode follows the press state while pulse mode settles back to all low
    function automatic key_vec_t expected_keys(input key_vec_t pressed);
        if (pulse_mode) begin
            return key_vec_t'(0);
        end
        return pressed;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge CLOCK_50);
    endtask

    // device side frame with data set while the clock is high and sampled on the fall
    // nbits below FRAME_BITS leaves the frame unfinished
    task automatic send_frame(input logic [7:0] data, input logic bad_parity, input int nbits);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_dat <= bits[i];
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b0;
            wait_cycles(HALF_BIT);
            ps2_clk <= 1'b1;
        end
        ps2_dat <= 1'b1;
        wait_cycles(HALF_BIT);
    endtask

    // full make or break sequence for a tracked key with the model updated alongside
    task automatic send_key(input key_index_e id, input logic down);
        if (KEY_TABLE[id].extended) begin
            send_frame(PREFIX_EXTENDED, 1'b0, FRAME_BITS);
        end
        if (!down) begin
            send_frame(PREFIX_BREAK, 1'b0, FRAME_BITS);
        end
        send_frame(KEY_TABLE[id].code, 1'b0, FRAME_BITS);
        // a pulse only when a released key goes down
        if (down && !press_model[id]) begin
            pulse_model++;
        end
        press_model[id] = down;
    endtask

    // break every key the model still holds
    task automatic release_all();
        for (int k = 0; k < KEY_COUNT; k++) begin
            if (press_model[k]) begin
                send_key(key_index_e'(k), 1'b0);
            end
        end
    endtask

    // hand the expected state to the monitor and wait for its answer
    task automatic check_outputs();
        int waited;
        exp_keys   <= expected_keys(press_model);
        exp_pulses <= pulse_model;
        check_req  <= 1'b1;
        waited = 0;
        @(posedge CLOCK_50);
        while (!check_done && waited < ANSWER_TIMEOUT) begin
            @(posedge CLOCK_50);
            waited++;
        end
        if (!check_done) begin
            tb_errors++;
            $display("monitor did not answer within %0d cycles", ANSWER_TIMEOUT);
        end
        check_req <= 1'b0;
        check_count++;
    endtask

    task automatic apply_reset();
        reset <= 1'b0;
        wait_cycles(10);
        reset <= 1'b1;
        press_model = '0;
    endtask

    initial begin
        key_index_e  id;
        logic [31:0] r;
        logic        down;
        CLOCK_50    = 1'b0;
        reset       = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        check_req   = 1'b0;
        exp_keys    = '0;
        exp_pulses  = 0;
        press_model = '0;
        pulse_model = 0;
        lfsr_state  = 32'h217d_0123;
        tb_errors   = 0;
        check_count = 0;
        wait_cycles(10);
        reset <= 1'b1;
        check_outputs();

        // random makes and breaks over all ten keys with random gaps
        repeat (24) begin
            take_bits(4, r);
            id = key_index_e'(4'(r % KEY_COUNT));
            take_bits(1, r);
            down = r[0];
            send_key(id, down);
            check_outputs();
            take_bits(5, r);
            wait_cycles(int'(r) + 10);
        end

        // all keys up so a wrong match cannot hide behind a held key
        release_all();
        check_outputs();

        // extended up and then codes that only match with the other flag
        send_key(KEY_UP, 1'b1);
        check_outputs();
        send_key(KEY_UP, 1'b0);
        check_outputs();
        send_frame(SC_UP, 1'b0, FRAME_BITS);
        check_outputs();
        send_frame(SC_RIGHT, 1'b0, FRAME_BITS);
        check_outputs();
        send_frame(PREFIX_EXTENDED, 1'b0, FRAME_BITS);
        send_frame(SC_W, 1'b0, FRAME_BITS);
        check_outputs();

        // typematic repeat while held
        send_key(KEY_SPACE, 1'b1);
        check_outputs();
        send_key(KEY_SPACE, 1'b1);
        check_outputs();
        send_key(KEY_SPACE, 1'b0);
        check_outputs();

        // corrupt parity is dropped and the next frame decodes
        send_key(KEY_A, 1'b0);
        check_outputs();
        send_frame(SC_A, 1'b1, FRAME_BITS);
        check_outputs();
        send_key(KEY_A, 1'b1);
        check_outputs();

        // five bits then silence past the idle window
        send_key(KEY_D, 1'b0);
        check_outputs();
        send_frame(SC_D, 1'b0, 5);
        wait_cycles(int'(IDLE_CYCLES) + 100);
        send_key(KEY_D, 1'b1);
        check_outputs();

        // reset while keys are down
        send_key(KEY_W, 1'b1);
        check_outputs();
        apply_reset();
        check_outputs();
        // press was cleared so a new make counts as a first press
        send_key(KEY_W, 1'b1);
        check_outputs();

        $display("checks %0d, monitor errors %0d, testbench errors %0d",
                 check_count, monitor_errors, tb_errors);
        if (monitor_errors == 0 && tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
src/ps2_pkg.sv
src/key_pkg.sv
src/ps2_frame_counter.sv
src/ps2_receiver.sv
src/scan_code_fsm.sv
src/key_state_table.sv
src/keyboard_tracker.sv
verification/key_monitor.sv
verification/tb_keyboard_tracker.sv

// ==== Bender.yml ====
package:
  name: keyboard_tracker

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/ps2_pkg.sv
      - src/key_pkg.sv
      - src/ps2_frame_counter.sv
      - src/ps2_receiver.sv
      - src/scan_code_fsm.sv
      - src/key_state_table.sv
      - src/keyboard_tracker.sv
  - target: simulation
    files:
      - verification/key_monitor.sv
      - verification/tb_keyboard_tracker.sv
